//--- rtl/udp_rx_pkg.sv
/*
 * UDP receive definitions
 * stream byte and header field types, header layout and parser states
 */
package udp_rx_pkg;

    // one byte of the input and output streams
    typedef logic [7:0] byte_t;

    // one UDP header field, carried big-endian on the wire
    typedef logic [15:0] word16_t;

    // fixed UDP header size in bytes
    localparam word16_t UDP_HDR_BYTES = 16'd8;

    // offset of the high byte of each field
    // the low byte follows at the next offset
    localparam word16_t OFS_SRC_PORT = 16'd0;
    localparam word16_t OFS_DST_PORT = 16'd2;
    localparam word16_t OFS_LENGTH   = 16'd4;
    localparam word16_t OFS_CHECKSUM = 16'd6;

    // header parser FSM
    typedef enum logic [1:0] {
        // wait for the previous header to be taken
        st_idle         = 2'd0,
        // collect the eight header bytes
        st_header       = 2'd1,
        // forward payload until length or tlast
        st_payload      = 2'd2,
        // length reached, drop the rest and hold the last byte
        st_payload_last = 2'd3
    } rx_state_e;

endpackage

//--- rtl/udp_hdr_parser.sv
/*
 * UDP header parser
 * strips the 8-byte UDP header from the input stream, presents the fields
 * with a valid/ready handshake and forwards the payload trimmed to length
 */
`timescale 1ns/10ps

module udp_hdr_parser import udp_rx_pkg::*; (
    input  logic      clk,
    input  logic      rst,

    // input byte stream, UDP datagram
    input  byte_t     s_tdata,
    input  logic      s_tvalid,
    output logic      s_tready,
    input  logic      s_tlast,
    input  logic      s_tuser,

    // parsed header
    output logic      hdr_valid,
    input  logic      hdr_ready,
    output word16_t   src_port,
    output word16_t   dst_port,
    output word16_t   udp_length,
    output word16_t   udp_checksum,

    // payload towards the skid buffer
    output byte_t     int_tdata,
    output logic      int_tvalid,
    output logic      int_tlast,
    output logic      int_tuser,
    input  logic      ready_early,

    // status
    output logic      busy,
    output logic      err_hdr_early,
    output logic      err_payload_early
);

    rx_state_e state_reg;
    rx_state_e state_next;

    word16_t frame_ptr_reg;
    word16_t frame_ptr_next;

    logic s_tready_next;
    logic hdr_valid_next;
    logic err_hdr_early_next;
    logic err_payload_early_next;

    // datapath strobes
    logic store_hdr;
    logic store_last;

    // last in-length byte, waits for the frame's tlast
    byte_t last_byte_reg;

    logic s_xfer;

    assign s_xfer = s_tready & s_tvalid;

    always_comb begin
        state_next = state_reg;
        frame_ptr_next = frame_ptr_reg;
        s_tready_next = 1'b0;

        // header stays up until the sink takes it
        hdr_valid_next = hdr_valid & ~hdr_ready;

        err_hdr_early_next = 1'b0;
        err_payload_early_next = 1'b0;

        store_hdr = 1'b0;
        store_last = 1'b0;

        int_tdata = s_tdata;
        int_tvalid = 1'b0;
        int_tlast = 1'b0;
        int_tuser = 1'b0;

        case (state_reg)
            st_idle: begin
                frame_ptr_next = '0;
                // first header byte, only once the previous header is gone
                s_tready_next = !hdr_valid;
                if (s_xfer) begin
                    store_hdr = 1'b1;
                    if (s_tlast) begin
                        // one-byte frame, drop it
                        err_hdr_early_next = 1'b1;
                        s_tready_next = 1'b0;
                    end else begin
                        frame_ptr_next = 16'd1;
                        state_next = st_header;
                    end
                end
            end

            st_header: begin
                s_tready_next = 1'b1;
                if (s_xfer) begin
                    store_hdr = 1'b1;
                    frame_ptr_next = frame_ptr_reg + 16'd1;
                    if (s_tlast) begin
                        // frame ended inside the header, drop it
                        err_hdr_early_next = 1'b1;
                        s_tready_next = 1'b0;
                        state_next = st_idle;
                    end else if (frame_ptr_reg == UDP_HDR_BYTES - 16'd1) begin
                        hdr_valid_next = 1'b1;
                        s_tready_next = ready_early;
                        state_next = st_payload;
                    end
                end
            end

            st_payload: begin
                s_tready_next = ready_early;

                int_tdata = s_tdata;
                int_tvalid = s_tvalid;
                int_tlast = s_tlast;
                int_tuser = s_tuser;

                if (s_xfer) begin
                    frame_ptr_next = frame_ptr_reg + 16'd1;
                    if (s_tlast) begin
                        if (frame_ptr_next != udp_length) begin
                            // shorter than the length field says
                            int_tuser = 1'b1;
                            err_payload_early_next = 1'b1;
                        end
                        s_tready_next = 1'b0;
                        state_next = st_idle;
                    end else if (frame_ptr_next == udp_length) begin
                        // keep this byte back until tlast shows up
                        store_last = 1'b1;
                        int_tvalid = 1'b0;
                        state_next = st_payload_last;
                    end
                end
            end

            st_payload_last: begin
                s_tready_next = ready_early;

                // trailing bytes are dropped, the held byte goes out with tlast
                int_tdata = last_byte_reg;
                int_tvalid = s_tvalid & s_tlast;
                int_tlast = s_tlast;
                int_tuser = s_tuser;

                if (s_xfer && s_tlast) begin
                    s_tready_next = 1'b0;
                    state_next = st_idle;
                end
            end

            default: begin
                state_next = st_idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_reg <= st_idle;
            frame_ptr_reg <= '0;
            s_tready <= 1'b0;
            hdr_valid <= 1'b0;
            busy <= 1'b0;
            err_hdr_early <= 1'b0;
            err_payload_early <= 1'b0;
        end else begin
            state_reg <= state_next;
            frame_ptr_reg <= frame_ptr_next;
            s_tready <= s_tready_next;
            hdr_valid <= hdr_valid_next;
            busy <= (state_next != st_idle);
            err_hdr_early <= err_hdr_early_next;
            err_payload_early <= err_payload_early_next;
        end

        // header fields, high byte first
        if (store_hdr) begin
            case (frame_ptr_reg)
                OFS_SRC_PORT:         src_port[15:8] <= s_tdata;
                OFS_SRC_PORT + 16'd1: src_port[7:0] <= s_tdata;
                OFS_DST_PORT:         dst_port[15:8] <= s_tdata;
                OFS_DST_PORT + 16'd1: dst_port[7:0] <= s_tdata;
                OFS_LENGTH:           udp_length[15:8] <= s_tdata;
                OFS_LENGTH + 16'd1:   udp_length[7:0] <= s_tdata;
                OFS_CHECKSUM:         udp_checksum[15:8] <= s_tdata;
                OFS_CHECKSUM + 16'd1: udp_checksum[7:0] <= s_tdata;
                default: begin
                end
            endcase
        end

        if (store_last) begin
            last_byte_reg <= s_tdata;
        end
    end

    // fields are only written while no header is pending
    a_hdr_stable: assert property (
        @(posedge clk) disable iff (rst)
        hdr_valid && !hdr_ready
            |=> hdr_valid && $stable({src_port, dst_port, udp_length, udp_checksum})
    );

endmodule

//--- rtl/udp_skid_buffer.sv
/*
 * Payload skid buffer
 * output register plus one temporary register, with a look-ahead ready
 */
`timescale 1ns/10ps

module udp_skid_buffer import udp_rx_pkg::*; (
    input  logic  clk,
    input  logic  rst,

    // from the parser
    input  byte_t int_tdata,
    input  logic  int_tvalid,
    input  logic  int_tlast,
    input  logic  int_tuser,
    output logic  ready_early,

    // to the payload sink
    output byte_t m_tdata,
    output logic  m_tvalid,
    input  logic  m_tready,
    output logic  m_tlast,
    output logic  m_tuser
);

    // registered copy of ready_early, same value the parser sees as s_tready
    logic ready_reg;

    logic m_tvalid_next;

    byte_t temp_tdata;
    logic  temp_tvalid;
    logic  temp_tvalid_next;
    logic  temp_tlast;
    logic  temp_tuser;

    logic int_to_out;
    logic int_to_temp;
    logic temp_to_out;

    // accept next cycle unless the temp register could end up full
    assign ready_early = m_tready | (~temp_tvalid & (~m_tvalid | ~int_tvalid));

    always_comb begin
        m_tvalid_next = m_tvalid;
        temp_tvalid_next = temp_tvalid;
        int_to_out = 1'b0;
        int_to_temp = 1'b0;
        temp_to_out = 1'b0;

        if (ready_reg) begin
            if (m_tready || !m_tvalid) begin
                // output free or draining
                m_tvalid_next = int_tvalid;
                int_to_out = 1'b1;
            end else begin
                // sink stalled, park the byte
                temp_tvalid_next = int_tvalid;
                int_to_temp = 1'b1;
            end
        end else if (m_tready) begin
            // refill from temp
            m_tvalid_next = temp_tvalid;
            temp_tvalid_next = 1'b0;
            temp_to_out = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ready_reg <= 1'b0;
            m_tvalid <= 1'b0;
            temp_tvalid <= 1'b0;
        end else begin
            ready_reg <= ready_early;
            m_tvalid <= m_tvalid_next;
            temp_tvalid <= temp_tvalid_next;
        end

        if (int_to_out) begin
            m_tdata <= int_tdata;
            m_tlast <= int_tlast;
            m_tuser <= int_tuser;
        end else if (temp_to_out) begin
            m_tdata <= temp_tdata;
            m_tlast <= temp_tlast;
            m_tuser <= temp_tuser;
        end

        if (int_to_temp) begin
            temp_tdata <= int_tdata;
            temp_tlast <= int_tlast;
            temp_tuser <= int_tuser;
        end
    end

    a_out_stable: assert property (
        @(posedge clk) disable iff (rst)
        m_tvalid && !m_tready |=> m_tvalid && $stable({m_tdata, m_tlast, m_tuser})
    );

    // temp only fills behind a stalled output byte
    a_temp_behind_out: assert property (
        @(posedge clk) disable iff (rst)
        temp_tvalid |-> m_tvalid
    );

endmodule

//--- rtl/udp_rx.sv
/*
 * UDP receive top level
 * header parser feeding the payload skid buffer
 */
`timescale 1ns/10ps

module udp_rx import udp_rx_pkg::*; (
    input  logic    clk,
    input  logic    rst,

    // UDP datagram in
    input  byte_t   s_tdata,
    input  logic    s_tvalid,
    output logic    s_tready,
    input  logic    s_tlast,
    input  logic    s_tuser,

    // header out
    output logic    hdr_valid,
    input  logic    hdr_ready,
    output word16_t src_port,
    output word16_t dst_port,
    output word16_t udp_length,
    output word16_t udp_checksum,

    // payload out
    output byte_t   m_tdata,
    output logic    m_tvalid,
    input  logic    m_tready,
    output logic    m_tlast,
    output logic    m_tuser,

    // status
    output logic    busy,
    output logic    err_hdr_early,
    output logic    err_payload_early
);

    // parser to skid buffer
    byte_t int_tdata;
    logic  int_tvalid;
    logic  int_tlast;
    logic  int_tuser;
    logic  ready_early;

    udp_hdr_parser u_parser (
        .clk               (clk),
        .rst               (rst),
        .s_tdata           (s_tdata),
        .s_tvalid          (s_tvalid),
        .s_tready          (s_tready),
        .s_tlast           (s_tlast),
        .s_tuser           (s_tuser),
        .hdr_valid         (hdr_valid),
        .hdr_ready         (hdr_ready),
        .src_port          (src_port),
        .dst_port          (dst_port),
        .udp_length        (udp_length),
        .udp_checksum      (udp_checksum),
        .int_tdata         (int_tdata),
        .int_tvalid        (int_tvalid),
        .int_tlast         (int_tlast),
        .int_tuser         (int_tuser),
        .ready_early       (ready_early),
        .busy              (busy),
        .err_hdr_early     (err_hdr_early),
        .err_payload_early (err_payload_early)
    );

    udp_skid_buffer u_skid (
        .clk         (clk),
        .rst         (rst),
        .int_tdata   (int_tdata),
        .int_tvalid  (int_tvalid),
        .int_tlast   (int_tlast),
        .int_tuser   (int_tuser),
        .ready_early (ready_early),
        .m_tdata     (m_tdata),
        .m_tvalid    (m_tvalid),
        .m_tready    (m_tready),
        .m_tlast     (m_tlast),
        .m_tuser     (m_tuser)
    );

endmodule

//--- sim/udp_rx_model.svh
/*
 * UDP receive reference model
 * builds random frames and predicts headers, payload beats and error pulses
 */
`ifndef UDP_RX_MODEL_SVH
`define UDP_RX_MODEL_SVH

// expected header as {src, dst, length, checksum}
logic [63:0] exp_hdr_q[$];

// expected payload beat as {frame kind, tuser, tlast, data}
// kind 0 exact length, 1 sent longer than length, 2 cut short
logic [11:0] exp_beat_q[$];

int exp_hdr_err = 0;
int exp_payload_err = 0;
int n_hdr_exp = 0;
int n_trimmed = 0;
int n_short = 0;

// bytes of the frame being sent, and tuser of its last byte
byte_t frame_q[$];
logic  frame_tuser;

function automatic void build_frame();
    int         len;
    int         sent;
    int         n_out;
    logic [1:0] kind;
    logic       last;
    logic       user;
    word16_t    src;
    word16_t    dst;
    word16_t    len_w;
    word16_t    csum;

    src = word16_t'($urandom);
    dst = word16_t'($urandom);
    csum = word16_t'($urandom);
    len = 9 + int'($urandom_range(31));
    len_w = word16_t'(len);
    kind = 2'd0;
    sent = len;
    case (int'($urandom_range(2)))
        1: begin
            if (len > 9) begin
                kind = 2'd2;
                sent = 9 + int'($urandom_range(len - 10));
            end
        end
        2: begin
            kind = 2'd1;
            sent = len + 1 + int'($urandom_range(7));
        end
        default: begin
        end
    endcase
    // roughly one frame in ten ends inside the header
    if ($urandom_range(9) == 0) begin
        sent = 1 + int'($urandom_range(7));
    end
    frame_tuser = ($urandom_range(1) != 0);

    // header goes out big-endian
    frame_q.delete();
    frame_q.push_back(src[15:8]);
    frame_q.push_back(src[7:0]);
    frame_q.push_back(dst[15:8]);
    frame_q.push_back(dst[7:0]);
    frame_q.push_back(len_w[15:8]);
    frame_q.push_back(len_w[7:0]);
    frame_q.push_back(csum[15:8]);
    frame_q.push_back(csum[7:0]);
    while (frame_q.size() < sent) begin
        frame_q.push_back(byte_t'($urandom));
    end
    while (frame_q.size() > sent) begin
        void'(frame_q.pop_back());
    end

    if (sent <= int'(UDP_HDR_BYTES)) begin
        exp_hdr_err++;
        return;
    end

    exp_hdr_q.push_back({src, dst, len_w, csum});
    n_hdr_exp++;
    n_out = (sent < len) ? sent - 8 : len - 8;
    for (int i = 0; i < n_out; i++) begin
        last = (i == n_out - 1);
        // short frames get tuser forced on their last byte
        user = last & ((sent < len) ? 1'b1 : frame_tuser);
        exp_beat_q.push_back({kind, user, last, frame_q[8 + i]});
    end
    if (kind == 2'd1) begin
        n_trimmed++;
    end
    if (sent < len) begin
        exp_payload_err++;
        n_short++;
    end
endfunction

`endif

//--- sim/udp_rx_tb.sv
/*
 * UDP receive testbench
 * random frames with valid gaps and output stalls, checked against the model
 */
`timescale 1ns/10ps

module udp_rx_tb import udp_rx_pkg::*; ();

    localparam int NUM_FRAMES = 200;
    // frames x worst-case bytes x cycles per byte x clock period
    localparam int WATCHDOG_NS = NUM_FRAMES * 48 * 8 * 4;

    logic    clk;
    logic    rst;
    byte_t   s_tdata;
    logic    s_tvalid;
    logic    s_tready;
    logic    s_tlast;
    logic    s_tuser;
    logic    hdr_valid;
    logic    hdr_ready;
    word16_t src_port;
    word16_t dst_port;
    word16_t udp_length;
    word16_t udp_checksum;
    byte_t   m_tdata;
    logic    m_tvalid;
    logic    m_tready;
    logic    m_tlast;
    logic    m_tuser;
    logic    busy;
    logic    err_hdr_early;
    logic    err_payload_early;

    `include "udp_rx_model.svh"

    int n_checks = 0;
    int err_hdr = 0;
    int err_beat = 0;
    int err_trim = 0;
    int err_short = 0;
    int err_trunc = 0;
    int err_idle = 0;
    int got_hdr_err = 0;
    int got_payload_err = 0;
    int n_hdr_seen = 0;
    int n_beats_seen = 0;
    int total_err = 0;

    udp_rx u_udp_rx (
        .clk               (clk),
        .rst               (rst),
        .s_tdata           (s_tdata),
        .s_tvalid          (s_tvalid),
        .s_tready          (s_tready),
        .s_tlast           (s_tlast),
        .s_tuser           (s_tuser),
        .hdr_valid         (hdr_valid),
        .hdr_ready         (hdr_ready),
        .src_port          (src_port),
        .dst_port          (dst_port),
        .udp_length        (udp_length),
        .udp_checksum      (udp_checksum),
        .m_tdata           (m_tdata),
        .m_tvalid          (m_tvalid),
        .m_tready          (m_tready),
        .m_tlast           (m_tlast),
        .m_tuser           (m_tuser),
        .busy              (busy),
        .err_hdr_early     (err_hdr_early),
        .err_payload_early (err_payload_early)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        $display("Verification failed");
        $finish;
    end

    // random sink stalls, driven just after each edge
    initial begin
        forever begin
            @(posedge clk);
            #1;
            hdr_ready = ($urandom_range(9) < 6);
            m_tready = ($urandom_range(9) < 7);
        end
    end

    task automatic send_frame();
        logic accepted;
        for (int i = 0; i < frame_q.size(); i++) begin
            if ($urandom_range(3) == 0) begin
                s_tvalid = 1'b0;
                repeat (int'($urandom_range(3, 1))) begin
                    @(posedge clk);
                    #1;
                end
            end
            s_tdata = frame_q[i];
            s_tvalid = 1'b1;
            s_tlast = (i == frame_q.size() - 1);
            s_tuser = (i == frame_q.size() - 1) ? frame_tuser : 1'b0;
            accepted = 1'b0;
            while (!accepted) begin
                @(negedge clk);
                accepted = s_tready;
                @(posedge clk);
                #1;
            end
        end
        s_tvalid = 1'b0;
        s_tlast = 1'b0;
        s_tuser = 1'b0;
    endtask

    function automatic void check_header();
        logic [63:0] exp;
        logic [63:0] got;
        got = {src_port, dst_port, udp_length, udp_checksum};
        n_checks++;
        n_hdr_seen++;
        if (exp_hdr_q.size() == 0) begin
            $display("header transfer at %0t while no header was expected", $time);
            err_hdr++;
        end else begin
            exp = exp_hdr_q.pop_front();
            if (got !== exp) begin
                $display("CHECK FAILED %0t: header %h expected %h", $time, got, exp);
                err_hdr++;
            end
        end
    endfunction

    function automatic void check_beat();
        logic [11:0] exp;
        logic [9:0]  got;
        got = {m_tuser, m_tlast, m_tdata};
        n_checks++;
        n_beats_seen++;
        if (exp_beat_q.size() == 0) begin
            $display("payload byte at %0t while no byte was expected", $time);
            err_beat++;
        end else begin
            exp = exp_beat_q.pop_front();
            if (got !== exp[9:0]) begin
                $display("CHECK FAILED %0t: payload tuser/tlast/data %h expected %h",
                    $time, got, exp[9:0]);
                err_beat++;
                if (exp[11:10] == 2'd1) begin
                    err_trim++;
                end
                if (exp[11:10] == 2'd2) begin
                    err_short++;
                end
            end
        end
    endfunction

    // sample mid-cycle, well away from the edge
    always @(negedge clk) begin
        if (!rst) begin
            if (hdr_valid && hdr_ready) begin
                check_header();
            end
            if (m_tvalid && m_tready) begin
                check_beat();
            end
            if (err_hdr_early) begin
                got_hdr_err++;
            end
            if (err_payload_early) begin
                got_payload_err++;
            end
        end
    end

    function automatic void report_test(string name, int errs);
        $display("%-28s %0d errors", name, errs);
    endfunction

    initial begin
        void'($urandom(83));
        rst = 1'b1;
        s_tdata = '0;
        s_tvalid = 1'b0;
        s_tlast = 1'b0;
        s_tuser = 1'b0;
        hdr_ready = 1'b0;
        m_tready = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;

        for (int f = 0; f < NUM_FRAMES; f++) begin
            build_frame();
            send_frame();
        end
        while (exp_hdr_q.size() != 0 || exp_beat_q.size() != 0) begin
            @(posedge clk);
        end
        repeat (4) @(posedge clk);
        #1;

        n_checks++;
        if (n_hdr_seen != n_hdr_exp) begin
            $display("CHECK FAILED %0t: %0d headers, expected %0d", $time, n_hdr_seen, n_hdr_exp);
            err_hdr++;
        end
        report_test("test 1 header fields", err_hdr);
        report_test("test 2 payload and framing", err_beat);
        $display("  %0d payload bytes, %0d trimmed frames", n_beats_seen, n_trimmed);
        report_test("test 3 trimming", err_trim);

        n_checks++;
        if (got_payload_err != exp_payload_err) begin
            $display("CHECK FAILED %0t: %0d payload early pulses, expected %0d",
                $time, got_payload_err, exp_payload_err);
            err_short++;
        end
        $display("  %0d short frames", n_short);
        report_test("test 4 payload early end", err_short);

        n_checks++;
        if (got_hdr_err != exp_hdr_err) begin
            $display("CHECK FAILED %0t: %0d header early pulses, expected %0d",
                $time, got_hdr_err, exp_hdr_err);
            err_trunc++;
        end
        report_test("test 5 header early end", err_trunc);

        n_checks++;
        if (busy || hdr_valid || m_tvalid) begin
            $display("CHECK FAILED %0t: busy %b hdr_valid %b m_tvalid %b after drain",
                $time, busy, hdr_valid, m_tvalid);
            err_idle++;
        end
        if (exp_hdr_q.size() != 0 || exp_beat_q.size() != 0) begin
            $display("model queues still hold entries after the drain");
            err_idle++;
        end
        report_test("test 6 idle after drain", err_idle);

        total_err = err_hdr + err_beat + err_short + err_trunc + err_idle;
        $display("%0d frames, %0d checks, %0d errors", NUM_FRAMES, n_checks, total_err);
        if (total_err == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

//--- udp_rx.f
+incdir+sim
rtl/udp_rx_pkg.sv
rtl/udp_hdr_parser.sv
rtl/udp_skid_buffer.sv
rtl/udp_rx.sv
sim/udp_rx_tb.sv

//--- Makefile
# Verilator simulation of the UDP receive parser

SIM      = verilator
FLAGS    = --binary --timing --assert
TOP      = udp_rx_tb
FILELIST = udp_rx.f
BUILD    = obj_dir
LOG      = sim.log
PASS_MSG = Verification passed

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
